//--- project.f
rtl/sv32_pkg.sv
rtl/sv32_tlb.sv
rtl/sv32_ptw.sv
rtl/sv32_mmu.sv
tests/axi_pt_memory.sv
tests/mmu_tb.sv

//--- rtl/sv32_mmu.sv
//////////////////////////////////////////////////
// SV32 translation top, four-phase client port
// TLB hit answers 2 cycles after req is sampled
// Faulting walks are not cached
// Permission faults from the TLB are still raised
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sv32_mmu import sv32_pkg::*; (
    input  wire          clk,
    input  wire          rst_n,

    input  wire          req,
    input  wire mmu_req_t req_data,
    output logic         ack,
    output mmu_resp_t    resp,

    input  wire [21:0]   satp_ppn,
    input  wire          tlb_flush,

    output logic         arvalid,
    input  wire          arready,
    output logic [33:0]  araddr,
    input  wire          rvalid,
    output logic         rready,
    input  wire axi_r_t  r
);

    mmu_state_t  state;
    mmu_req_t    req_q;

    logic        tlb_hit;
    tlb_entry_t  tlb_entry;
    logic        tlb_fill;
    logic        walk_start;
    logic        walk_done;
    ptw_result_t walk_result;
    logic [7:0]  check_meta;
    logic        denied;

    // Load needs R, store needs W, fetch needs X
    function automatic logic access_allowed(input access_t acc, input logic [7:0] meta);
        logic ok;
        case (acc)
            access_store: ok = meta[pte_w_bit];
            access_fetch: ok = meta[pte_x_bit];
            default:      ok = meta[pte_r_bit];
        endcase
        return ok;
    endfunction

    // Metadata comes from the TLB in lookup, else from the walker
    assign check_meta = (state == mmu_lookup) ? tlb_entry.metadata : walk_result.metadata;
    assign denied     = !access_allowed(req_q.access, check_meta);

    // Miss starts the walker for one cycle
    assign walk_start = (state == mmu_lookup) && !tlb_hit;
    // Only clean walks are cached
    assign tlb_fill   = (state == mmu_walk) && walk_done &&
                        !walk_result.page_fault && !walk_result.access_fault;

    sv32_tlb sv32_tlb_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .lookup_vpn    (req_q.vpn),
        .hit           (tlb_hit),
        .entry         (tlb_entry),
        .fill_en       (tlb_fill),
        .fill_vpn      (req_q.vpn),
        .fill_ppn      (walk_result.ppn),
        .fill_metadata (walk_result.metadata),
        .flush         (tlb_flush)
    );

    sv32_ptw sv32_ptw_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .walk_start (walk_start),
        .vpn        (req_q.vpn),
        .satp_ppn   (satp_ppn),
        .walk_done  (walk_done),
        .result     (walk_result),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .r          (r)
    );

    //////////////////////////////////////////////////
    // Client FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= mmu_idle;
            ack   <= 1'b0;
        end else begin
            case (state)
                mmu_idle: begin
                    if (req) begin
                        state <= mmu_lookup;
                    end
                end
                mmu_lookup: begin
                    state <= tlb_hit ? mmu_respond : mmu_walk;
                end
                mmu_walk: begin
                    if (walk_done) begin
                        state <= mmu_respond;
                    end
                end
                default: begin
                    // Raise ack, then hold it until req falls
                    if (!ack) begin
                        ack <= 1'b1;
                    end else if (!req) begin
                        ack   <= 1'b0;
                        state <= mmu_idle;
                    end
                end
            endcase
        end
    end

    // Request capture and response register
    always_ff @(posedge clk) begin
        if (state == mmu_idle) begin
            req_q <= req_data;
        end
        if (state == mmu_lookup && tlb_hit) begin
            resp.ppn          <= tlb_entry.ppn;
            resp.page_fault   <= denied;
            resp.access_fault <= 1'b0;
        end
        if (state == mmu_walk && walk_done) begin
            resp.ppn          <= walk_result.ppn;
            // Access fault masks any page fault
            resp.access_fault <= walk_result.access_fault;
            resp.page_fault   <= !walk_result.access_fault &&
                                 (walk_result.page_fault || denied);
        end
    end

endmodule

`default_nettype wire

//--- rtl/sv32_pkg.sv
//////////////////////////////////////////////////
// Shared types for the SV32 translation unit
// Paging is assumed on; there is no SATP mode bit
// No user/supervisor privilege and no A/D bits
// TLB size is fixed here and not by parameter
//////////////////////////////////////////////////

`default_nettype none

package sv32_pkg;

    //////////////////////////////////////////////////
    // Page table entry layout
    //////////////////////////////////////////////////

    // Metadata flag positions in the low PTE byte
    localparam int pte_v_bit = 0;
    localparam int pte_r_bit = 1;
    localparam int pte_w_bit = 2;
    localparam int pte_x_bit = 3;

    // Virtual and physical page number widths
    localparam int vpn_bits = 20;
    localparam int ppn_bits = 22;

    //////////////////////////////////////////////////
    // TLB geometry
    //////////////////////////////////////////////////

    // 8 entries, direct mapped
    localparam int tlb_index_bits = 3;
    localparam int tlb_entries    = 1 << tlb_index_bits;
    // Upper vpn bits left for the tag
    localparam int tlb_tag_bits   = vpn_bits - tlb_index_bits;

    // Requested access kind
    typedef enum logic [1:0] {
        access_load,
        access_store,
        access_fetch
    } access_t;

    // Walker FSM
    typedef enum logic [1:0] {
        ptw_idle,
        ptw_read_addr,
        ptw_read_data,
        ptw_decode
    } ptw_state_t;

    // Top-level FSM
    typedef enum logic [1:0] {
        mmu_idle,
        mmu_lookup,
        mmu_walk,
        mmu_respond
    } mmu_state_t;

    // Client request, held stable while req is high
    typedef struct packed {
        logic [vpn_bits-1:0] vpn;
        access_t             access;
    } mmu_req_t;

    // Client response, valid while ack is high
    typedef struct packed {
        logic [ppn_bits-1:0] ppn;
        logic                page_fault;
        logic                access_fault;
    } mmu_resp_t;

    // Walker result, valid only in the walk_done cycle
    typedef struct packed {
        logic [ppn_bits-1:0] ppn;
        logic [7:0]          metadata;
        logic                page_fault;
        logic                access_fault;
    } ptw_result_t;

    // One cached translation, always a 4K page
    typedef struct packed {
        logic                    valid;
        logic [tlb_tag_bits-1:0] tag;
        logic [ppn_bits-1:0]     ppn;
        logic [7:0]              metadata;
    } tlb_entry_t;

    // Read data beat; last is carried but single-beat only
    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } axi_r_t;

endpackage

`default_nettype wire

//--- rtl/sv32_ptw.sv
//////////////////////////////////////////////////
// Two-level SV32 walker, always yields 4K pages
// Megapages are expanded with vpn[9:0]
// One outstanding single-beat read; rlast ignored
// start/done handshake, done is a one-cycle pulse
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sv32_ptw import sv32_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,

    input  wire               walk_start,
    input  wire [19:0]        vpn,
    input  wire [21:0]        satp_ppn,
    output logic              walk_done,
    output ptw_result_t       result,

    output logic              arvalid,
    input  wire               arready,
    output logic [33:0]       araddr,
    input  wire               rvalid,
    output logic              rready,
    input  wire axi_r_t       r
);

    ptw_state_t  state;
    // 1 = root table, 0 = leaf table
    logic        level;
    logic [21:0] table_base;
    logic [19:0] vpn_q;
    logic [31:0] pte_q;
    logic        bus_error;

    // Decode outputs
    logic        descend;
    logic        fault_page;
    logic        fault_access;

    // Flags of the latched entry
    logic        pte_valid;
    logic        pte_read;
    logic        pte_write;
    logic        pte_exec;
    logic        pte_bad;
    logic        pte_leaf;
    logic        misaligned;

    assign pte_valid = pte_q[pte_v_bit];
    assign pte_read  = pte_q[pte_r_bit];
    assign pte_write = pte_q[pte_w_bit];
    assign pte_exec  = pte_q[pte_x_bit];

    // Not valid, or writable without read (reserved)
    assign pte_bad    = !pte_valid || (pte_write && !pte_read);
    assign pte_leaf   = pte_read || pte_exec;
    // Megapage leaf must have ppn0 clear
    assign misaligned = level && (pte_q[19:10] != 10'd0);

    //////////////////////////////////////////////////
    // Read channel
    //////////////////////////////////////////////////

    // Table base * 4096 + vpn slice * 4
    assign araddr  = {table_base, (level ? vpn_q[19:10] : vpn_q[9:0]), 2'b00};
    assign arvalid = (state == ptw_read_addr);
    // Never stall the return path
    assign rready  = (state == ptw_read_data) && rvalid;

    //////////////////////////////////////////////////
    // Entry classification, priority order
    //////////////////////////////////////////////////

    always_comb begin
        walk_done    = 1'b0;
        descend      = 1'b0;
        fault_page   = 1'b0;
        fault_access = 1'b0;
        if (state == ptw_decode) begin
            if (bus_error) begin
                fault_access = 1'b1;
                walk_done    = 1'b1;
            end else if (pte_bad) begin
                fault_page = 1'b1;
                walk_done  = 1'b1;
            end else if (pte_leaf) begin
                fault_page = misaligned;
                walk_done  = 1'b1;
            end else if (level) begin
                // Pointer from the root table
                descend = 1'b1;
            end else begin
                // Pointer where a leaf was expected
                fault_page = 1'b1;
                walk_done  = 1'b1;
            end
        end
    end

    // Low ppn from vpn for a megapage, from the PTE otherwise
    assign result.ppn          = {pte_q[31:20], (level ? vpn_q[9:0] : pte_q[19:10])};
    assign result.metadata     = pte_q[7:0];
    assign result.page_fault   = fault_page;
    assign result.access_fault = fault_access;

    // Walker FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ptw_idle;
            level <= 1'b1;
        end else begin
            case (state)
                ptw_idle: begin
                    level <= 1'b1;
                    if (walk_start) begin
                        state <= ptw_read_addr;
                    end
                end
                ptw_read_addr: begin
                    if (arready) begin
                        state <= ptw_read_data;
                    end
                end
                ptw_read_data: begin
                    if (rvalid) begin
                        state <= ptw_decode;
                    end
                end
                default: begin
                    if (descend) begin
                        level <= 1'b0;
                        state <= ptw_read_addr;
                    end else begin
                        state <= ptw_idle;
                    end
                end
            endcase
        end
    end

    // Walk context and fetched entry
    always_ff @(posedge clk) begin
        if (state == ptw_idle && walk_start) begin
            vpn_q      <= vpn;
            table_base <= satp_ppn;
        end
        if (descend) begin
            table_base <= pte_q[31:10];
        end
        if (state == ptw_read_data && rvalid) begin
            pte_q     <= r.data;
            bus_error <= (r.resp != 2'b00);
        end
    end

endmodule

`default_nettype wire

//--- rtl/sv32_tlb.sv
//////////////////////////////////////////////////
// Direct-mapped TLB, size from the package
// Lookup is combinational, fill and flush clocked
// Flush beats a fill in the same cycle
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sv32_tlb import sv32_pkg::*; (
    input  wire          clk,
    input  wire          rst_n,

    input  wire [19:0]   lookup_vpn,
    output logic         hit,
    output tlb_entry_t   entry,

    input  wire          fill_en,
    input  wire [19:0]   fill_vpn,
    input  wire [21:0]   fill_ppn,
    input  wire [7:0]    fill_metadata,

    input  wire          flush
);

    // Valid bits are the only state cleared by reset
    logic [tlb_entries-1:0]  valid_q;

    // Payload storage
    logic [tlb_tag_bits-1:0] tag_mem  [tlb_entries];
    logic [21:0]             ppn_mem  [tlb_entries];
    logic [7:0]              meta_mem [tlb_entries];

    logic [tlb_index_bits-1:0] lookup_idx;
    logic [tlb_index_bits-1:0] fill_idx;

    // Low vpn bits select the set
    assign lookup_idx = lookup_vpn[tlb_index_bits-1:0];
    assign fill_idx   = fill_vpn[tlb_index_bits-1:0];

    //////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////

    assign entry.valid    = valid_q[lookup_idx];
    assign entry.tag      = tag_mem[lookup_idx];
    assign entry.ppn      = ppn_mem[lookup_idx];
    assign entry.metadata = meta_mem[lookup_idx];

    // Upper vpn bits must match the stored tag
    assign hit = entry.valid && (entry.tag == lookup_vpn[19:tlb_index_bits]);

    //////////////////////////////////////////////////
    // Fill and flush
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    // Payload write; harmless under flush as valid stays clear
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_idx]  <= fill_vpn[19:tlb_index_bits];
            ppn_mem[fill_idx]  <= fill_ppn;
            meta_mem[fill_idx] <= fill_metadata;
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the SV32 MMU testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module mmu_tb -f project.f
./obj_dir/Vmmu_tb | tee sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

//--- tests/axi_pt_memory.sv
//////////////////////////////////////////////////
// Testbench AXI read slave over a word array
// Decodes araddr[14:2] only, so 8K words alias
// One read at a time, single beat, random delays
// Contents are written by the testbench directly
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module axi_pt_memory import sv32_pkg::*; (
    input  wire          clk,
    input  wire          rst_n,
    input  wire          arvalid,
    output logic         arready,
    input  wire [33:0]   araddr,
    output logic         rvalid,
    input  wire          rready,
    output axi_r_t       r
);

    // Page table words and per-word error flags
    logic [31:0] words    [8192];
    logic        err_flag [8192];

    integer      seed = 32'h384d;
    // Address taken, data not yet returned
    logic        pending;
    logic [1:0]  delay;
    logic [12:0] idx;

    always @(posedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            pending <= 1'b0;
            delay   <= 2'd0;
            idx     <= 13'd0;
            r       <= '0;
        end else begin
            if (arvalid && arready) begin
                // Address accepted, pick a read latency of 0 to 3
                arready <= 1'b0;
                pending <= 1'b1;
                idx     <= araddr[14:2];
                delay   <= 2'($random(seed));
            end else begin
                // Ready about three cycles in four while free
                arready <= !pending && !rvalid && (($random(seed) & 3) != 0);
            end
            if (pending) begin
                if (delay == 2'd0) begin
                    pending <= 1'b0;
                    rvalid  <= 1'b1;
                    r.data  <= words[idx];
                    // SLVERR on flagged words
                    r.resp  <= err_flag[idx] ? 2'b10 : 2'b00;
                    r.last  <= 1'b1;
                end else begin
                    delay <= delay - 2'd1;
                end
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/mmu_tb.sv
//////////////////////////////////////////////////
// Testbench for the SV32 MMU
// Root table at ppn 0, memory holds 8 pages
// Tables change only while the MMU is idle,
// always followed by a TLB flush
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mmu_tb import sv32_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic        req;
    mmu_req_t    req_data;
    logic        ack;
    mmu_resp_t   resp;
    logic [21:0] satp_ppn;
    logic        tlb_flush;
    logic        arvalid;
    logic        arready;
    logic [33:0] araddr;
    logic        rvalid;
    logic        rready;
    axi_r_t      r;

    // Expected response of the request in flight
    mmu_resp_t   exp_resp;
    logic        ack_seen = 1'b0;
    int          ar_count = 0;
    // AR count when the request in flight started
    int          req_ar_start = 0;
    int          cycle_count = 0;
    integer      seed;

    sv32_mmu sv32_mmu_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_data  (req_data),
        .ack       (ack),
        .resp      (resp),
        .satp_ppn  (satp_ppn),
        .tlb_flush (tlb_flush),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .r         (r)
    );

    axi_pt_memory mem_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .r       (r)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("[FAIL] time %0t: %s is %0h, expected %0h", $time, name, got, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model of walk and permission rules
    //////////////////////////////////////////////////

    function automatic mmu_resp_t ref_translate(input logic [21:0] root, input mmu_req_t rq);
        mmu_resp_t   res;
        logic [21:0] base;
        logic [9:0]  slice;
        logic [12:0] idx;
        logic [31:0] pte;
        logic        allowed;
        res  = '0;
        base = root;
        for (int level = 1; level >= 0; level--) begin
            slice = (level == 1) ? rq.vpn[19:10] : rq.vpn[9:0];
            // Same aliasing as the memory model
            idx   = {base[2:0], slice};
            pte   = mem_i.words[idx];
            if (mem_i.err_flag[idx]) begin
                res.access_fault = 1'b1;
                return res;
            end
            if (!pte[pte_v_bit] || (pte[pte_w_bit] && !pte[pte_r_bit])) begin
                res.page_fault = 1'b1;
                return res;
            end
            if (pte[pte_r_bit] || pte[pte_x_bit]) begin
                // Megapage needs ppn0 clear
                if (level == 1 && pte[19:10] != 10'd0) begin
                    res.page_fault = 1'b1;
                    return res;
                end
                res.ppn = (level == 1) ? {pte[31:20], rq.vpn[9:0]} : pte[31:10];
                case (rq.access)
                    access_store: allowed = pte[pte_w_bit];
                    access_fetch: allowed = pte[pte_x_bit];
                    default:      allowed = pte[pte_r_bit];
                endcase
                res.page_fault = !allowed;
                return res;
            end
            if (level == 0) begin
                res.page_fault = 1'b1;
                return res;
            end
            base = pte[31:10];
        end
        return res;
    endfunction

    // First read hits the root table, the second the page the root entry points to
    function automatic logic [33:0] expected_araddr(input int read_no);
        logic [31:0] root_pte;
        root_pte = mem_i.words[{satp_ppn[2:0], req_data.vpn[19:10]}];
        if (read_no == 0) begin
            return {satp_ppn, req_data.vpn[19:10], 2'b00};
        end
        return {root_pte[31:10], req_data.vpn[9:0], 2'b00};
    endfunction

    //////////////////////////////////////////////////
    // Monitors and timeout
    //////////////////////////////////////////////////

    // Response check on each rise of ack; ppn only matters without a fault
    always @(negedge clk) begin
        if (ack && !ack_seen) begin
            check_value("resp.access_fault", 32'(resp.access_fault),
                        32'(exp_resp.access_fault));
            check_value("resp.page_fault", 32'(resp.page_fault), 32'(exp_resp.page_fault));
            if (!exp_resp.page_fault && !exp_resp.access_fault) begin
                check_value("resp.ppn", 32'(resp.ppn), 32'(exp_resp.ppn));
            end
        end
        ack_seen = ack;
    end

    // AR handshake completes at the next rising edge
    always @(negedge clk) begin
        if (arvalid && arready) begin
            check_value("araddr", araddr, expected_araddr(ar_count - req_ar_start));
            ar_count = ar_count + 1;
        end
        // Walker takes the beat in the cycle it is offered
        check_value("rready", 32'(rready), 32'(rvalid));
    end

    // About 250 requests at up to 30 cycles each, plus margin
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= 10000) begin
            $display("Timeout: the run did not finish within 10000 clock cycles");
            $display("SOME TESTS FAILED");
            $fatal(1, "Simulation stopped by timeout");
        end
    end

    //////////////////////////////////////////////////
    // Table setup and client driver
    //////////////////////////////////////////////////

    function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    task automatic put_pte(input int table_page, input int slot, input logic [31:0] pte);
        mem_i.words[table_page * 1024 + slot] = pte;
    endtask

    task automatic clear_tables();
        for (int i = 0; i < 8192; i++) begin
            // Invalid entries, upper bits follow the word index
            mem_i.words[i]    = {i[23:0], 8'h00};
            mem_i.err_flag[i] = 1'b0;
        end
    endtask

    task automatic setup_directed_tables();
        // Root: pointer to page 1, aligned megapage, misaligned megapage
        put_pte(0, 0, make_pte(22'h00001, 8'h01));
        put_pte(0, 1, make_pte({12'habc, 10'h000}, 8'h0f));
        put_pte(0, 2, make_pte({12'h123, 10'h005}, 8'h03));
        // Leaf table in page 1; slot 4 stays invalid
        put_pte(1, 1, make_pte(22'h12345, 8'h03));
        put_pte(1, 2, make_pte(22'h2abcd, 8'h07));
        put_pte(1, 3, make_pte(22'h3f00f, 8'h0b));
        // W without R
        put_pte(1, 5, make_pte(22'h00055, 8'h05));
        // Pointer at level 0
        put_pte(1, 6, make_pte(22'h00002, 8'h01));
        put_pte(1, 7, make_pte(22'h00077, 8'h03));
        // Same TLB set as vpn 1
        put_pte(1, 9, make_pte(22'h00777, 8'h03));
        mem_i.err_flag[1024 + 7] = 1'b1;
    endtask

    task automatic build_random_tables();
        logic [31:0] pte;
        for (int i = 0; i < 8192; i++) begin
            pte = $random(seed);
            // Mostly valid
            if (($random(seed) & 7) != 0) begin
                pte[pte_v_bit] = 1'b1;
            end
            // Root table leans toward pointers
            if (i < 1024 && ($random(seed) & 1) != 0) begin
                pte = make_pte(pte[31:10], 8'h01);
            end
            mem_i.words[i]    = pte;
            mem_i.err_flag[i] = (($random(seed) & 31) == 0);
        end
    endtask

    task automatic flush_tlb();
        tlb_flush = 1'b1;
        @(negedge clk);
        tlb_flush = 1'b0;
    endtask

    // One four-phase transaction; starts and ends just after a falling edge
    task automatic run_request(input logic [19:0] vpn, input access_t acc,
                               output int latency, output int walks);
        int waited;
        int hold;
        req_data.vpn    = vpn;
        req_data.access = acc;
        exp_resp        = ref_translate(satp_ppn, req_data);
        req_ar_start    = ar_count;
        req             = 1'b1;
        waited          = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack);
        // ack must hold while req stays high
        hold = $random(seed) & 3;
        repeat (hold) begin
            @(negedge clk);
            check_value("ack", 32'(ack), 32'd1);
        end
        req = 1'b0;
        @(negedge clk);
        check_value("ack", 32'(ack), 32'd0);
        // First falling edge is the one after req was sampled
        latency = waited - 1;
        walks   = ar_count - req_ar_start;
    endtask

    // TLB hits need no reads and answer after 2 cycles
    task automatic walk_check(input logic [19:0] vpn, input access_t acc, input int exp_reads);
        int latency;
        int walks;
        run_request(vpn, acc, latency, walks);
        check_value("ar_handshakes", walks, exp_reads);
        if (exp_reads == 0) begin
            check_value("hit_latency", latency, 2);
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        int          latency;
        int          walks;
        logic [19:0] vpn;
        access_t     acc;
        logic [31:0] rnd;
        seed      = 32'h384d;
        rst_n     = 1'b0;
        req       = 1'b0;
        req_data  = '0;
        satp_ppn  = 22'd0;
        tlb_flush = 1'b0;
        clear_tables();
        setup_directed_tables();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Two-level walks with matching permissions
        walk_check(20'h00001, access_load, 2);
        walk_check(20'h00002, access_store, 2);
        walk_check(20'h00003, access_fetch, 2);
        // Megapage, then misaligned megapage
        walk_check(20'h00555, access_load, 1);
        walk_check(20'h008aa, access_fetch, 1);
        // Invalid, W without R, level 0 pointer, bus error
        walk_check(20'h00004, access_load, 2);
        walk_check(20'h00005, access_load, 2);
        walk_check(20'h00006, access_load, 2);
        walk_check(20'h00007, access_load, 2);
        // Permission faults served from the TLB
        walk_check(20'h00001, access_store, 0);
        walk_check(20'h00002, access_fetch, 0);
        walk_check(20'h00555, access_store, 0);
        // Repeats, faults walk again
        walk_check(20'h00001, access_load, 0);
        walk_check(20'h00004, access_load, 2);
        walk_check(20'h00007, access_load, 2);
        flush_tlb();
        walk_check(20'h00001, access_load, 2);
        walk_check(20'h00003, access_fetch, 2);
        // Denied store on a walk still caches the page
        flush_tlb();
        walk_check(20'h00001, access_store, 2);
        walk_check(20'h00001, access_load, 0);
        // vpn 9 evicts vpn 1 from set 1
        walk_check(20'h00009, access_load, 2);
        walk_check(20'h00001, access_load, 2);

        // Random tables, accesses and memory delays
        for (int n = 0; n < 200; n++) begin
            if (n % 100 == 0) begin
                build_random_tables();
                flush_tlb();
            end
            rnd = $random(seed);
            // 32 vpns over the 8 TLB sets
            vpn = {8'd0, rnd[1:0], 7'd0, rnd[4:2]};
            acc = access_t'((rnd[9:8] == 2'd3) ? 2'd0 : rnd[9:8]);
            run_request(vpn, acc, latency, walks);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
